// ==== bench/ooo_core_chk.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_chk (
    input logic             clk,
    input logic             rst,
    input logic             flush_pulse,
    input logic             inst_req,
    input logic             inst_ack,
    input logic             commit_valid,
    input ooo_pkg::commit_s commit
);
    import ooo_pkg::*;

    tag_t next_tag; // Tag of the buffer entry that must retire next.

    // The buffer restarts at entry 0 after reset and after a flush.
    always_ff @(posedge clk) begin
        if (rst || flush_pulse) begin
            next_tag <= tag_t'(1);
        end else if (commit_valid) begin
            next_tag <= (next_tag == tag_t'(`OOO_ROB_DEPTH)) ? tag_t'(1) : next_tag + 1'b1;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_ack) |-> $past(inst_req))
        else $error("inst_ack rose without a pending inst_req");

    ack_holds: assert property (@(posedge clk) disable iff (rst)
        inst_ack && inst_req |=> inst_ack)
        else $error("inst_ack dropped while inst_req was still high");

    commit_in_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> commit.tag == next_tag)
        else $error("commit tag %0d is out of buffer order", commit.tag);

    no_commit_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !commit_valid)
        else $error("commit_valid is high during reset");

endmodule

bind ooo_core_top ooo_core_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .flush_pulse  (flush_pulse),
    .inst_req     (inst_req),
    .inst_ack     (inst_ack),
    .commit_valid (commit_valid),
    .commit       (commit)
);

// ==== bench/ooo_core_tb.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_INST = 200;
    localparam int DRAIN_LIMIT     = 64;

    logic    clk;
    logic    rst;
    logic    flush;
    logic    inst_req;
    inst_s   inst_in;
    logic    inst_ack;
    logic    commit_valid;
    commit_s commit;

    data_t   spec_regs [`OOO_REG_NUM]; // Program-order view, updated at issue.
    data_t   arch_regs [`OOO_REG_NUM]; // Built from verified commits only.
    commit_s exp_q [$];
    commit_s exp_head;
    tag_t    alloc_tag; // Tag the buffer hands out next.
    data_t   last_value;
    string   cur_test;
    integer  seed;
    int      issued;
    int      commit_count;
    int      ack_commits;
    int      mismatch_errors;
    int      other_errors;
    int      wd_cycles;

    ooo_core_top dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .inst_req     (inst_req),
        .inst_in      (inst_in),
        .inst_ack     (inst_ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t model_alu(input op_e op, input data_t a, input data_t b,
                                        input data_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? data_t'(1) : data_t'(0);
            OP_ADDI: return a + imm;
            default: return imm; // LUI passes the immediate through.
        endcase
    endfunction

    function automatic data_t next_random();
        return $random(seed);
    endfunction

    // Every retirement is checked against the oldest expected one.
    always @(posedge clk) begin
        if (!rst && commit_valid === 1'b1) begin
            commit_count++;
            last_value = commit.value;
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("Unexpected commit to x%0d in %s with nothing outstanding",
                         commit.rd, cur_test);
            end
            if (exp_q.size() != 0) begin
                exp_head = exp_q.pop_front();
                assert (commit.rd == exp_head.rd) else begin
                    mismatch_errors++;
                    $display("Mismatch in %s: expected rd x%0d, actual rd x%0d",
                             cur_test, exp_head.rd, commit.rd);
                end
                assert (commit.value == exp_head.value) else begin
                    mismatch_errors++;
                    $display("Mismatch in %s: expected %h, actual %h",
                             cur_test, exp_head.value, commit.value);
                end
                assert (commit.tag == exp_head.tag) else begin
                    mismatch_errors++;
                    $display("Mismatch in %s: expected tag %0d, actual tag %0d",
                             cur_test, exp_head.tag, commit.tag);
                end
                if (exp_head.rd != '0) begin
                    arch_regs[exp_head.rd] = exp_head.value;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Called on a falling edge with the handshake idle.
    task automatic send_inst(input op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                             input reg_addr_t rs2, input data_t imm);
        commit_s exp_c;
        exp_c.rd    = rd;
        exp_c.value = model_alu(op, spec_regs[rs1], spec_regs[rs2], imm);
        exp_c.tag   = alloc_tag;
        exp_q.push_back(exp_c);
        // Every instruction takes an entry, x0 writers too.
        alloc_tag = (alloc_tag == tag_t'(`OOO_ROB_DEPTH)) ? tag_t'(1) : alloc_tag + 1'b1;
        if (rd != '0) begin
            spec_regs[rd] = exp_c.value;
        end
        assert (inst_ack == 1'b0) else begin
            other_errors++;
            $display("Acknowledge was still high when a request started in %s", cur_test);
        end
        inst_in.op  = op;
        inst_in.rd  = rd;
        inst_in.rs1 = rs1;
        inst_in.rs2 = rs2;
        inst_in.imm = imm;
        inst_req    = 1'b1;
        issued++;
        @(negedge clk);
        while (inst_ack !== 1'b1) @(negedge clk);
        ack_commits = commit_count;
        inst_req    = 1'b0;
        @(negedge clk);
        while (inst_ack !== 1'b0) @(negedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("%0d instruction(s) issued in %s never committed",
                     exp_q.size(), cur_test);
            exp_q.delete();
            spec_regs = arch_regs;
        end
    endtask

    // Anything still outstanding once the pulse has passed is gone for good.
    task automatic apply_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (2) @(negedge clk);
        exp_q.delete();
        spec_regs = arch_regs;
        alloc_tag = tag_t'(1); // The buffer starts over from its first entry.
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic independent_ops();
        cur_test = "independent_ops";
        for (int r = 1; r <= 4; r++) begin
            send_inst(OP_LUI, reg_addr_t'(r), '0, '0, next_random());
        end
        send_inst(OP_LUI, 5'd0, '0, '0, next_random()); // Retires while x0 keeps zero.
        send_inst(OP_ADD, 5'd5, 5'd1, 5'd2, '0);
        send_inst(OP_SUB, 5'd6, 5'd1, 5'd2, '0);
        send_inst(OP_AND, 5'd7, 5'd3, 5'd4, '0);
        send_inst(OP_OR, 5'd8, 5'd3, 5'd4, '0);
        send_inst(OP_XOR, 5'd9, 5'd1, 5'd4, '0);
        send_inst(OP_SLT, 5'd10, 5'd1, 5'd2, '0);
        send_inst(OP_SLT, 5'd11, 5'd2, 5'd1, '0);
        send_inst(OP_ADDI, 5'd12, 5'd3, '0, next_random());
        send_inst(OP_ADD, 5'd0, 5'd1, 5'd2, '0);
        send_inst(OP_ADD, 5'd13, 5'd0, 5'd0, '0);
        wait_drain();
    endtask

    task automatic dependency_chain();
        cur_test = "dependency_chain";
        send_inst(OP_LUI, 5'd14, '0, '0, next_random());
        send_inst(OP_ADDI, 5'd15, 5'd14, '0, next_random());
        send_inst(OP_ADD, 5'd16, 5'd15, 5'd15, '0);
        send_inst(OP_SUB, 5'd17, 5'd16, 5'd15, '0);
        send_inst(OP_XOR, 5'd18, 5'd17, 5'd16, '0);
        send_inst(OP_SLT, 5'd19, 5'd18, 5'd17, '0);
        send_inst(OP_OR, 5'd14, 5'd19, 5'd18, '0);
        wait_drain();
    endtask

    task automatic write_after_write();
        data_t younger;
        cur_test = "write_after_write";
        younger  = next_random();
        send_inst(OP_ADDI, 5'd20, 5'd0, '0, next_random());
        send_inst(OP_ADDI, 5'd20, 5'd0, '0, younger);
        send_inst(OP_ADD, 5'd21, 5'd20, 5'd0, '0);
        wait_drain();
        send_inst(OP_ADD, 5'd22, 5'd20, 5'd0, '0);
        wait_drain();
        assert (last_value == younger) else begin
            mismatch_errors++;
            $display("Mismatch in %s: expected %h, actual %h",
                     cur_test, younger, last_value);
        end
    endtask

    task automatic buffer_backpressure();
        int start_commits;
        cur_test      = "buffer_backpressure";
        start_commits = commit_count;
        for (int r = 23; r < 23 + `OOO_ROB_DEPTH; r++) begin
            send_inst(OP_ADDI, reg_addr_t'(r), '0, '0, next_random());
        end
        send_inst(OP_ADD, 5'd31, 5'd23, 5'd30, '0);
        assert (ack_commits > start_commits) else begin
            other_errors++;
            $display("The ninth instruction in %s was acknowledged before any commit",
                     cur_test);
        end
        wait_drain();
    endtask

    task automatic flush_recovery();
        int flush_commits;
        cur_test = "flush_recovery";
        send_inst(OP_ADDI, 5'd3, 5'd3, '0, next_random());
        send_inst(OP_ADDI, 5'd4, 5'd3, '0, next_random());
        apply_flush();
        flush_commits = commit_count;
        repeat (10) @(negedge clk);
        assert (commit_count == flush_commits) else begin
            other_errors++;
            $display("Commits kept appearing after the flush in %s", cur_test);
        end
        send_inst(OP_ADD, 5'd24, 5'd4, 5'd3, '0);
        send_inst(OP_XOR, 5'd25, 5'd3, 5'd24, '0);
        wait_drain();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////////////////////

    // The allowance grows with every issued instruction.
    initial begin
        wd_cycles = 0;
        while (wd_cycles <= RESET_CYCLES + CYCLES_PER_INST * (issued + 1)) begin
            @(posedge clk);
            wd_cycles++;
        end
        other_errors++;
        $display("Watchdog expired after %0d cycles in %s with %0d instructions issued",
                 wd_cycles, cur_test, issued);
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        flush           = 1'b0;
        inst_req        = 1'b0;
        inst_in         = '0;
        seed            = 32'h9be4_31fe;
        alloc_tag       = tag_t'(1);
        last_value      = '0;
        issued          = 0;
        commit_count    = 0;
        ack_commits     = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        cur_test        = "reset";
        for (int i = 0; i < `OOO_REG_NUM; i++) begin
            spec_regs[i] = '0;
            arch_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        independent_ops();
        dependency_chain();
        write_after_write();
        buffer_backpressure();
        flush_recovery();
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/ooo_pkg.sv
hw/rename_regfile.sv
hw/reorder_buffer.sv
hw/alu_pipe.sv
hw/issue_ctrl.sv
hw/ooo_core_top.sv
bench/ooo_core_chk.sv
bench/ooo_core_tb.sv

// ==== hw/alu_pipe.sv ====
`timescale 1ns/1ps

module alu_pipe (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_pulse,
    input  logic             exec_valid,
    input  ooo_pkg::exec_s   exec,
    output logic             res_valid,
    output ooo_pkg::result_s res
);
    import ooo_pkg::*;

    logic  s1_valid;
    op_e   s1_op;
    tag_t  s1_tag;
    data_t s1_a;
    data_t s1_b;
    data_t s1_imm;
    logic  s1_sub;
    data_t sum;
    logic  less;
    data_t s2_value;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1 operand capture and decode
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush_pulse) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op  <= exec.op;
        s1_tag <= exec.tag;
        s1_a   <= exec.a;
        s1_imm <= exec.imm;
        // Subtract and compare share the adder with b inverted and a carry in.
        s1_sub <= (exec.op == OP_SUB) || (exec.op == OP_SLT);
        s1_b   <= ((exec.op == OP_SUB) || (exec.op == OP_SLT)) ? ~exec.b : exec.b;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2 compute
    ////////////////////////////////////////////////////////////////////////////

    assign sum  = s1_a + s1_b + s1_sub;
    // With differing signs the sign of a decides, otherwise the difference does.
    assign less = (s1_a[`OOO_XLEN-1] == s1_b[`OOO_XLEN-1]) ? s1_a[`OOO_XLEN-1]
                                                           : sum[`OOO_XLEN-1];

    always_comb begin
        case (s1_op)
            OP_AND:  s2_value = s1_a & s1_b;
            OP_OR:   s2_value = s1_a | s1_b;
            OP_XOR:  s2_value = s1_a ^ s1_b;
            OP_SLT:  s2_value = data_t'(less);
            OP_LUI:  s2_value = s1_imm;
            default: s2_value = sum; // ADD, ADDI and SUB.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_pulse) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        res.tag   <= s1_tag;
        res.value <= s2_value;
    end

endmodule

// ==== hw/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               inst_req,
    input  ooo_pkg::inst_s     inst_in,
    output logic               inst_ack,
    output ooo_pkg::reg_addr_t rs1_addr,
    output ooo_pkg::reg_addr_t rs2_addr,
    input  ooo_pkg::operand_s  rs1_op,
    input  ooo_pkg::operand_s  rs2_op,
    output ooo_pkg::tag_t      lookup_tag1,
    output ooo_pkg::tag_t      lookup_tag2,
    input  ooo_pkg::data_t     lookup_val1,
    input  ooo_pkg::data_t     lookup_val2,
    input  logic               lookup_done1,
    input  logic               lookup_done2,
    input  logic               rob_full,
    input  ooo_pkg::tag_t      free_tag,
    output logic               alloc_en,
    output logic               claim_en,
    output ooo_pkg::reg_addr_t claim_rd,
    output ooo_pkg::tag_t      claim_tag,
    output logic               exec_valid,
    output ooo_pkg::exec_s     exec,
    output logic               flush_pulse
);
    import ooo_pkg::*;

    ctrl_state_e state;
    inst_s       inst_q;
    logic        use_imm;
    logic        ready1;
    logic        ready2;
    logic        accept;
    data_t       opnd1;
    data_t       opnd2;

    ////////////////////////////////////////////////////////////////////////////
    // Operand resolution
    ////////////////////////////////////////////////////////////////////////////

    assign rs1_addr    = inst_q.rs1;
    assign rs2_addr    = inst_q.rs2;
    assign lookup_tag1 = rs1_op.tag;
    assign lookup_tag2 = rs2_op.tag;

    assign use_imm = (inst_q.op == OP_ADDI) || (inst_q.op == OP_LUI);

    // A pending producer hands over its finished value from the buffer.
    assign opnd1  = (rs1_op.tag == '0) ? rs1_op.value : lookup_val1;
    assign opnd2  = (rs2_op.tag == '0) ? rs2_op.value : lookup_val2;
    assign ready1 = (inst_q.op == OP_LUI) || (rs1_op.tag == '0) || lookup_done1;
    assign ready2 = use_imm || (rs2_op.tag == '0) || lookup_done2;
    assign accept = (state == RESOLVE) && !rob_full && ready1 && ready2;

    // Issue happens on the accepting edge itself.
    assign alloc_en   = accept;
    assign claim_en   = accept && (inst_q.rd != '0);
    assign claim_rd   = inst_q.rd;
    assign claim_tag  = free_tag;
    assign exec_valid = accept;
    assign exec       = '{op: inst_q.op, tag: free_tag, a: opnd1,
                          b: use_imm ? inst_q.imm : opnd2, imm: inst_q.imm};

    assign flush_pulse = (state == FLUSH);

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            inst_ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (flush) begin
                        state <= FLUSH;
                    end else if (inst_req) begin
                        state <= RESOLVE;
                    end
                end
                RESOLVE: begin
                    if (accept) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (!inst_ack) begin
                        inst_ack <= 1'b1; // One edge after acceptance.
                    end else if (!inst_req) begin
                        inst_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                FLUSH:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && inst_req && !flush) begin
            inst_q <= inst_in;
        end
    end

endmodule

// ==== hw/ooo_core_top.sv ====
`timescale 1ns/1ps

module ooo_core_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             inst_req,
    input  ooo_pkg::inst_s   inst_in,
    output logic             inst_ack,
    output logic             commit_valid,
    output ooo_pkg::commit_s commit
);
    import ooo_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    operand_s  rs1_op;
    operand_s  rs2_op;
    tag_t      lookup_tag1;
    tag_t      lookup_tag2;
    data_t     lookup_val1;
    data_t     lookup_val2;
    logic      lookup_done1;
    logic      lookup_done2;
    logic      rob_full;
    tag_t      free_tag;
    logic      alloc_en;
    logic      claim_en;
    reg_addr_t claim_rd;
    tag_t      claim_tag;
    logic      exec_valid;
    exec_s     exec;
    logic      res_valid;
    result_s   res;
    logic      flush_pulse;

    issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .inst_req     (inst_req),
        .inst_in      (inst_in),
        .inst_ack     (inst_ack),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_op       (rs1_op),
        .rs2_op       (rs2_op),
        .lookup_tag1  (lookup_tag1),
        .lookup_tag2  (lookup_tag2),
        .lookup_val1  (lookup_val1),
        .lookup_val2  (lookup_val2),
        .lookup_done1 (lookup_done1),
        .lookup_done2 (lookup_done2),
        .rob_full     (rob_full),
        .free_tag     (free_tag),
        .alloc_en     (alloc_en),
        .claim_en     (claim_en),
        .claim_rd     (claim_rd),
        .claim_tag    (claim_tag),
        .exec_valid   (exec_valid),
        .exec         (exec),
        .flush_pulse  (flush_pulse)
    );

    rename_regfile u_rename_regfile (
        .clk          (clk),
        .rst          (rst),
        .flush_pulse  (flush_pulse),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_op       (rs1_op),
        .rs2_op       (rs2_op),
        .claim_en     (claim_en),
        .claim_rd     (claim_rd),
        .claim_tag    (claim_tag),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // The destination travels with the allocation even for x0.
    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .flush_pulse  (flush_pulse),
        .alloc_en     (alloc_en),
        .alloc_rd     (claim_rd),
        .full         (rob_full),
        .free_tag     (free_tag),
        .res_valid    (res_valid),
        .res          (res),
        .lookup_tag1  (lookup_tag1),
        .lookup_tag2  (lookup_tag2),
        .lookup_val1  (lookup_val1),
        .lookup_val2  (lookup_val2),
        .lookup_done1 (lookup_done1),
        .lookup_done2 (lookup_done2),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    alu_pipe u_alu_pipe (
        .clk          (clk),
        .rst          (rst),
        .flush_pulse  (flush_pulse),
        .exec_valid   (exec_valid),
        .exec         (exec),
        .res_valid    (res_valid),
        .res          (res)
    );

endmodule

// ==== hw/ooo_params.svh ====
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Core sizes
////////////////////////////////////////////////////////////////////////////

// Width of every register and ALU datapath.
`define OOO_XLEN 32

// Architectural registers, x0 included.
`define OOO_REG_NUM 32

// In-flight instructions between issue and retirement.
`define OOO_ROB_DEPTH 8

// Entry number plus one, so that zero can mean no producer.
`define OOO_TAG_W 4

`endif

// ==== hw/ooo_pkg.sv ====
`include "ooo_params.svh"

package ooo_pkg;

    localparam int ROB_AW = $clog2(`OOO_ROB_DEPTH);
    localparam int REG_AW = $clog2(`OOO_REG_NUM);

    typedef logic [`OOO_XLEN-1:0]  data_t;
    typedef logic [REG_AW-1:0]     reg_addr_t;
    typedef logic [`OOO_TAG_W-1:0] tag_t;      // 0 means the value is committed.
    typedef logic [ROB_AW-1:0]     rob_idx_t;

    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_LUI
    } op_e;

    typedef enum logic [1:0] {
        IDLE, RESOLVE, ACK, FLUSH
    } ctrl_state_e;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;
    } inst_s;

    typedef struct packed {
        data_t value;
        tag_t  tag;
    } operand_s;

    // The b operand already carries the immediate for OP_ADDI and OP_LUI.
    typedef struct packed {
        op_e   op;
        tag_t  tag;
        data_t a;
        data_t b;
        data_t imm;
    } exec_s;

    typedef struct packed {
        tag_t  tag;
        data_t value;
    } result_s;

    typedef struct packed {
        reg_addr_t rd;
        data_t     value;
        tag_t      tag;
    } commit_s;

endpackage

// ==== hw/rename_regfile.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module rename_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush_pulse,
    input  ooo_pkg::reg_addr_t rs1_addr,
    input  ooo_pkg::reg_addr_t rs2_addr,
    output ooo_pkg::operand_s  rs1_op,
    output ooo_pkg::operand_s  rs2_op,
    input  logic               claim_en,
    input  ooo_pkg::reg_addr_t claim_rd,
    input  ooo_pkg::tag_t      claim_tag,
    input  logic               commit_valid,
    input  ooo_pkg::commit_s   commit
);
    import ooo_pkg::*;

    data_t reg_val [`OOO_REG_NUM];
    tag_t  reg_tag [`OOO_REG_NUM];
    logic  commit_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Operand read
    ////////////////////////////////////////////////////////////////////////////

    // Both ports see the arrays as they stand before the clock edge, so an
    // instruction that renames its own source still reads the older producer.
    always_comb begin
        rs1_op.value = reg_val[rs1_addr];
        rs1_op.tag   = reg_tag[rs1_addr];
        if (rs1_addr == '0) begin
            rs1_op = '0;
        end
    end

    always_comb begin
        rs2_op.value = reg_val[rs2_addr];
        rs2_op.tag   = reg_tag[rs2_addr];
        if (rs2_addr == '0) begin
            rs2_op = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Commit and rename
    ////////////////////////////////////////////////////////////////////////////

    // A retiring value lands only if its producer is still the newest one.
    // x0 never holds a tag, so a commit to x0 never hits.
    assign commit_hit = commit_valid && (reg_tag[commit.rd] == commit.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_REG_NUM; i++) begin
                reg_val[i] <= '0;
                reg_tag[i] <= '0;
            end
        end else begin
            if (commit_hit) begin
                reg_val[commit.rd] <= commit.value;
                reg_tag[commit.rd] <= '0;
            end

            // Placed after the commit so that a claim in the same cycle keeps the tag.
            if (flush_pulse) begin
                for (int i = 0; i < `OOO_REG_NUM; i++) begin
                    reg_tag[i] <= '0; // Committed values survive.
                end
            end else if (claim_en) begin
                reg_tag[claim_rd] <= claim_tag;
            end
        end
    end

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush_pulse,
    input  logic               alloc_en,
    input  ooo_pkg::reg_addr_t alloc_rd,
    output logic               full,
    output ooo_pkg::tag_t      free_tag,
    input  logic               res_valid,
    input  ooo_pkg::result_s   res,
    input  ooo_pkg::tag_t      lookup_tag1,
    input  ooo_pkg::tag_t      lookup_tag2,
    output ooo_pkg::data_t     lookup_val1,
    output ooo_pkg::data_t     lookup_val2,
    output logic               lookup_done1,
    output logic               lookup_done2,
    output logic               commit_valid,
    output ooo_pkg::commit_s   commit
);
    import ooo_pkg::*;

    reg_addr_t                 ent_rd  [`OOO_ROB_DEPTH];
    data_t                     ent_val [`OOO_ROB_DEPTH];
    logic [`OOO_ROB_DEPTH-1:0] ent_valid;
    logic [`OOO_ROB_DEPTH-1:0] ent_done;

    rob_idx_t        head;
    rob_idx_t        tail;
    logic [ROB_AW:0] count;

    rob_idx_t res_idx;
    rob_idx_t idx1;
    rob_idx_t idx2;

    // Tags are entry numbers offset by one.
    assign res_idx = rob_idx_t'(res.tag - 1'b1);
    assign idx1    = rob_idx_t'(lookup_tag1 - 1'b1);
    assign idx2    = rob_idx_t'(lookup_tag2 - 1'b1);

    assign full     = (count == `OOO_ROB_DEPTH);
    assign free_tag = tag_t'(tail) + tag_t'(1);

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////////////////////

    assign lookup_val1  = ent_val[idx1];
    assign lookup_val2  = ent_val[idx2];
    assign lookup_done1 = (lookup_tag1 != '0) && ent_valid[idx1] && ent_done[idx1];
    assign lookup_done2 = (lookup_tag2 != '0) && ent_valid[idx2] && ent_done[idx2];

    // Retire from the head only, one per cycle. Nothing retires while flushing.
    assign commit_valid = !flush_pulse && ent_valid[head] && ent_done[head];
    assign commit       = '{rd: ent_rd[head], value: ent_val[head],
                            tag: tag_t'(head) + tag_t'(1)};

    ////////////////////////////////////////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush_pulse) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (res_valid && ent_valid[res_idx]) begin
                ent_done[res_idx] <= 1'b1;
            end
            if (commit_valid) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            if (alloc_en) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;
                tail            <= tail + 1'b1;
            end
            case ({alloc_en, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            ent_rd[tail] <= alloc_rd;
        end
        if (res_valid) begin
            ent_val[res_idx] <= res.value;
        end
    end

endmodule
